// File: logic/uart_phy_pkg.sv
// Serial line definitions shared by the UART receiver, the transmitter
// and the command engine that sits between them
package uart_phy_pkg;

  // Clock cycles per serial bit, fixed for the whole design
  localparam int unsigned clks_per_bit = 16;

  typedef logic [7:0] uart_byte_t;

  // Receiver to engine, valid high for one cycle per good byte
  typedef struct packed {
    logic       valid;
    uart_byte_t data;
  } rx_beat_t;

  // Engine to transmitter, send only while the transmitter is ready
  typedef struct packed {
    logic       send;
    uart_byte_t data;
  } tx_req_t;

endpackage

// File: logic/uart_dbg_pkg.sv
// Debug protocol definitions for the command engine and its memory.
// The byte values match the host loader, so the testbench uses them too.
package uart_dbg_pkg;

  ////////////////////////////////////////////////////////////
  // Protocol bytes
  ////////////////////////////////////////////////////////////

  localparam uart_phy_pkg::uart_byte_t cmd_read  = 8'h11;
  localparam uart_phy_pkg::uart_byte_t cmd_write = 8'h12;
  localparam uart_phy_pkg::uart_byte_t cmd_exec  = 8'h13;
  localparam uart_phy_pkg::uart_byte_t dbg_ack   = 8'h06;
  localparam uart_phy_pkg::uart_byte_t dbg_eot   = 8'h04;

  // Address and length fields are both sent as 8 bytes, LSB first
  localparam int unsigned hdr_bytes = 8;

  ////////////////////////////////////////////////////////////
  // Address, length and memory types
  ////////////////////////////////////////////////////////////

  localparam int unsigned mem_depth = 256;

  typedef logic [63:0]                  dbg_addr_t;
  typedef logic [15:0]                  dbg_len_t;
  typedef logic [$clog2(mem_depth)-1:0] mem_idx_t;

  typedef enum logic [2:0] {
    idle,
    get_addr,
    get_len,
    send_ack,
    xfer_in,
    xfer_out,
    send_eot,
    exec_ack
  } engine_state_e;

endpackage

// File: logic/uart_rx.sv
// 8N1 UART receiver sampling each bit in its middle.
// Emits one valid beat per byte, or a frame error pulse on a low stop bit.
`timescale 1ns/1ps

module uart_rx import uart_phy_pkg::*; (
  input  logic     clk,
  input  logic     rst_i,
  input  logic     rxd_i,
  output rx_beat_t rx_beat_o,
  output logic     frame_err_o
);

  localparam int unsigned cnt_w = $clog2(clks_per_bit);

  typedef enum logic [1:0] {rx_idle, rx_start, rx_data, rx_stop} rx_state_e;

  rx_state_e        state_q;
  logic [cnt_w-1:0] cnt_q;
  logic [2:0]       bit_q;
  // Two synchronizer stages, the top bit keeps the previous level
  logic [2:0]       sync_q;
  uart_byte_t       data_q;
  logic             valid_q;
  logic             err_q;
  logic             rxd_s;
  logic             half_done;
  logic             bit_done;

  assign rxd_s     = sync_q[1];
  assign half_done = cnt_q == cnt_w'(clks_per_bit / 2 - 1);
  assign bit_done  = cnt_q == cnt_w'(clks_per_bit - 1);

  always_ff @(posedge clk) begin
    if (rst_i) begin
      sync_q  <= '1;
      state_q <= rx_idle;
      cnt_q   <= '0;
      bit_q   <= '0;
      valid_q <= 1'b0;
      err_q   <= 1'b0;
    end else begin
      sync_q  <= {sync_q[1:0], rxd_i};
      valid_q <= 1'b0;
      err_q   <= 1'b0;
      cnt_q   <= cnt_q + 1'b1;
      unique case (state_q)
        rx_idle: begin
          cnt_q <= '0;
          // Falling edge starts a frame
          if (sync_q[2] && !rxd_s) state_q <= rx_start;
        end
        rx_start: begin
          if (half_done) begin
            cnt_q   <= '0;
            bit_q   <= '0;
            // Line back high at mid-bit means a glitch
            state_q <= rxd_s ? rx_idle : rx_data;
          end
        end
        rx_data: begin
          if (bit_done) begin
            bit_q <= bit_q + 1'b1;
            if (bit_q == 3'd7) state_q <= rx_stop;
          end
        end
        rx_stop: begin
          if (bit_done) begin
            state_q <= rx_idle;
            valid_q <= rxd_s;
            err_q   <= !rxd_s;
          end
        end
        default: state_q <= rx_idle;
      endcase
    end
  end

  // Data bits arrive LSB first
  always_ff @(posedge clk) begin
    if (state_q == rx_data && bit_done) data_q <= {rxd_s, data_q[7:1]};
  end

  assign rx_beat_o.valid = valid_q;
  assign rx_beat_o.data  = data_q;
  assign frame_err_o     = err_q;

  beat_or_error_a: assert property (@(posedge clk) disable iff (rst_i)
    !(rx_beat_o.valid && frame_err_o));

endmodule

// File: logic/uart_tx.sv
// 8N1 UART transmitter.
// Takes one byte per send strobe while ready; ready returns after the stop bit.
`timescale 1ns/1ps

module uart_tx import uart_phy_pkg::*; (
  input  logic    clk,
  input  logic    rst_i,
  input  tx_req_t tx_req_i,
  output logic    txd_o,
  output logic    tx_ready_o
);

  localparam int unsigned cnt_w      = $clog2(clks_per_bit);
  // Start, eight data bits and stop
  localparam int unsigned frame_bits = 10;

  logic [cnt_w-1:0] cnt_q;
  logic [3:0]       bit_q;
  logic [8:0]       shift_q;
  logic             txd_q;
  logic             ready_q;
  logic             bit_done;

  assign bit_done = cnt_q == cnt_w'(clks_per_bit - 1);

  always_ff @(posedge clk) begin
    if (rst_i) begin
      txd_q   <= 1'b1;
      ready_q <= 1'b1;
      cnt_q   <= '0;
      bit_q   <= '0;
    end else if (ready_q) begin
      cnt_q <= '0;
      bit_q <= '0;
      if (tx_req_i.send) begin
        txd_q   <= 1'b0;
        ready_q <= 1'b0;
      end
    end else begin
      cnt_q <= cnt_q + 1'b1;
      if (bit_done) begin
        if (bit_q == 4'(frame_bits - 1)) begin
          ready_q <= 1'b1;
        end else begin
          txd_q <= shift_q[0];
          bit_q <= bit_q + 1'b1;
        end
      end
    end
  end

  // Data bits then the stop bit, shifted out LSB first
  always_ff @(posedge clk) begin
    if (ready_q && tx_req_i.send) begin
      shift_q <= {1'b1, tx_req_i.data};
    end else if (!ready_q && bit_done) begin
      shift_q <= {1'b1, shift_q[8:1]};
    end
  end

  assign txd_o      = txd_q;
  assign tx_ready_o = ready_q;

  no_send_when_busy_a: assert property (@(posedge clk) disable iff (rst_i)
    tx_req_i.send |-> tx_ready_o);

endmodule

// File: logic/dbg_mem.sv
// Byte memory behind the debug engine.
// Synchronous write, registered read with one cycle of latency.
`timescale 1ns/1ps

module dbg_mem import uart_phy_pkg::*, uart_dbg_pkg::*; (
  input  logic       clk,
  input  mem_idx_t   idx_i,
  input  logic       we_i,
  input  uart_byte_t wdata_i,
  output uart_byte_t rdata_o
);

  uart_byte_t mem_q [mem_depth];
  uart_byte_t rdata_q;

  // Read returns the old contents on a same-cycle write
  always_ff @(posedge clk) begin
    if (we_i) mem_q[idx_i] <= wdata_i;
    rdata_q <= mem_q[idx_i];
  end

  assign rdata_o = rdata_q;

endmodule

// File: logic/dbg_cmd_engine.sv
// Debug protocol engine between the UART pair and the byte memory.
// Decodes ACK, read, write and exec commands and sequences the replies.
`timescale 1ns/1ps

module dbg_cmd_engine import uart_phy_pkg::*, uart_dbg_pkg::*; (
  input  logic       clk,
  input  logic       rst_i,
  input  rx_beat_t   rx_beat_i,
  input  logic       tx_ready_i,
  input  uart_byte_t mem_rdata_i,
  output tx_req_t    tx_req_o,
  output mem_idx_t   mem_idx_o,
  output logic       mem_we_o,
  output uart_byte_t mem_wdata_o,
  output logic       exec_o,
  output dbg_addr_t  exec_addr_o
);

  localparam int unsigned cnt_w     = $clog2(hdr_bytes);
  // Only the low length bytes count, the rest is ignored
  localparam int unsigned len_bytes = $bits(dbg_len_t) / 8;

  engine_state_e    state_q;
  uart_byte_t       cmd_q;
  dbg_addr_t        addr_q;
  dbg_len_t         len_q;
  dbg_len_t         off_q;
  dbg_len_t         off_nxt;
  logic [cnt_w-1:0] cnt_q;
  logic             rd_wait_q;
  logic             rx_ok;
  uart_byte_t       rx_byte;
  logic             hdr_last;
  logic             data_last;
  logic             sent;

  assign rx_ok     = rx_beat_i.valid;
  assign rx_byte   = rx_beat_i.data;
  assign hdr_last  = cnt_q == cnt_w'(hdr_bytes - 1);
  assign off_nxt   = off_q + 1'b1;
  assign data_last = off_nxt == len_q;
  assign sent      = tx_req_o.send;

  ////////////////////////////////////////////////////////////
  // State machine
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (rst_i) begin
      state_q   <= idle;
      cnt_q     <= '0;
      off_q     <= '0;
      rd_wait_q <= 1'b0;
    end else begin
      rd_wait_q <= 1'b0;
      unique case (state_q)
        idle: begin
          cnt_q <= '0;
          off_q <= '0;
          if (rx_ok) begin
            if (rx_byte == dbg_ack) begin
              state_q <= send_ack;
            end else if (rx_byte inside {cmd_read, cmd_write, cmd_exec}) begin
              state_q <= get_addr;
            end
          end
        end
        get_addr: begin
          if (rx_ok) begin
            cnt_q <= cnt_q + 1'b1;
            // Exec has no length field
            if (hdr_last) state_q <= (cmd_q == cmd_exec) ? send_ack : get_len;
          end
        end
        get_len: begin
          if (rx_ok) begin
            cnt_q <= cnt_q + 1'b1;
            if (hdr_last) state_q <= send_ack;
          end
        end
        send_ack: begin
          if (sent) begin
            rd_wait_q <= 1'b1;
            if (cmd_q == cmd_exec) begin
              state_q <= exec_ack;
            end else if (cmd_q == dbg_ack) begin
              state_q <= idle;
            end else if (len_q == '0) begin
              state_q <= send_eot;
            end else if (cmd_q == cmd_write) begin
              state_q <= xfer_in;
            end else begin
              state_q <= xfer_out;
            end
          end
        end
        xfer_in: begin
          if (rx_ok) begin
            off_q <= off_nxt;
            if (data_last) state_q <= send_eot;
          end
        end
        xfer_out: begin
          if (sent) begin
            off_q     <= off_nxt;
            rd_wait_q <= 1'b1;
            if (data_last) state_q <= send_eot;
          end
        end
        send_eot: if (sent) state_q <= idle;
        exec_ack: state_q <= idle;
        default:  state_q <= idle;
      endcase
    end
  end

  // Header fields, shifted in little-endian from the top
  always_ff @(posedge clk) begin
    if (state_q == idle && rx_ok) cmd_q <= rx_byte;
    if (state_q == get_addr && rx_ok) begin
      addr_q <= {rx_byte, addr_q[$bits(dbg_addr_t)-1:8]};
    end
    if (state_q == get_len && rx_ok && cnt_q < cnt_w'(len_bytes)) begin
      len_q <= {rx_byte, len_q[$bits(dbg_len_t)-1:8]};
    end
  end

  ////////////////////////////////////////////////////////////
  // Transmit requests, memory and exec
  ////////////////////////////////////////////////////////////

  always_comb begin
    tx_req_o.send = 1'b0;
    tx_req_o.data = dbg_ack;
    unique case (state_q)
      send_ack: tx_req_o.send = tx_ready_i;
      xfer_out: begin
        // Hold off until the read data matches the current offset
        tx_req_o.send = tx_ready_i && !rd_wait_q;
        tx_req_o.data = mem_rdata_i;
      end
      send_eot: begin
        tx_req_o.send = tx_ready_i;
        tx_req_o.data = dbg_eot;
      end
      default: ;
    endcase
  end

  // Index wraps modulo the memory depth
  assign mem_idx_o   = mem_idx_t'(addr_q) + mem_idx_t'(off_q);
  assign mem_we_o    = (state_q == xfer_in) && rx_ok;
  assign mem_wdata_o = rx_byte;
  assign exec_o      = state_q == exec_ack;
  assign exec_addr_o = addr_q;

  exec_single_pulse_a: assert property (@(posedge clk) disable iff (rst_i)
    exec_o |=> !exec_o);

  mem_we_in_write_a: assert property (@(posedge clk) disable iff (rst_i)
    mem_we_o |-> (state_q == xfer_in) && (cmd_q == cmd_write));

endmodule

// File: logic/uart_dbg_top.sv
// UART debug server top level.
// Receiver, command engine, byte memory and transmitter on one clock.
`timescale 1ns/1ps

module uart_dbg_top import uart_phy_pkg::*, uart_dbg_pkg::*; (
  input  logic      clk,
  input  logic      rst_i,
  input  logic      rxd_i,
  output logic      txd_o,
  output logic      exec_o,
  output dbg_addr_t exec_addr_o,
  output logic      frame_err_o
);

  rx_beat_t   rx_beat;
  tx_req_t    tx_req;
  logic       tx_ready;
  mem_idx_t   mem_idx;
  logic       mem_we;
  uart_byte_t mem_wdata;
  uart_byte_t mem_rdata;

  uart_rx i_uart_rx (
    .clk         ( clk         ),
    .rst_i       ( rst_i       ),
    .rxd_i       ( rxd_i       ),
    .rx_beat_o   ( rx_beat     ),
    .frame_err_o ( frame_err_o )
  );

  dbg_cmd_engine i_engine (
    .clk         ( clk         ),
    .rst_i       ( rst_i       ),
    .rx_beat_i   ( rx_beat     ),
    .tx_ready_i  ( tx_ready    ),
    .mem_rdata_i ( mem_rdata   ),
    .tx_req_o    ( tx_req      ),
    .mem_idx_o   ( mem_idx     ),
    .mem_we_o    ( mem_we      ),
    .mem_wdata_o ( mem_wdata   ),
    .exec_o      ( exec_o      ),
    .exec_addr_o ( exec_addr_o )
  );

  dbg_mem i_mem (
    .clk     ( clk       ),
    .idx_i   ( mem_idx   ),
    .we_i    ( mem_we    ),
    .wdata_i ( mem_wdata ),
    .rdata_o ( mem_rdata )
  );

  uart_tx i_uart_tx (
    .clk        ( clk      ),
    .rst_i      ( rst_i    ),
    .tx_req_i   ( tx_req   ),
    .txd_o      ( txd_o    ),
    .tx_ready_o ( tx_ready )
  );

endmodule

// File: testbench/tb_uart_dbg_checker.sv
// Reply checker for the UART debug server testbench.
// Deserializes txd and compares reply bytes, exec pulses and frame error
// pulses, in order, against the expected tables from the testbench top.
`timescale 1ns/1ps

module tb_uart_dbg_checker import uart_phy_pkg::*, uart_dbg_pkg::*; #(
  parameter int unsigned max_replies = 64,
  parameter int unsigned max_execs   = 4
) (
  input  logic        clk,
  input  logic        rst_i,
  input  logic        txd_i,
  input  logic        exec_i,
  input  dbg_addr_t   exec_addr_i,
  input  logic        frame_err_i,
  input  uart_byte_t  exp_reply_i [max_replies],
  input  dbg_addr_t   exp_exec_i [max_execs],
  input  int unsigned exp_reply_n_i,
  input  int unsigned exp_exec_n_i,
  input  int unsigned exp_ferr_n_i,
  input  logic        done_i,
  output int unsigned reply_seen_o,
  output int unsigned exec_seen_o,
  output int unsigned ferr_seen_o,
  output int unsigned value_errs_o,
  output int unsigned event_errs_o
);

  localparam int unsigned half_bit  = clks_per_bit / 2;
  localparam int unsigned stop_slot = 9;

  logic        busy;
  int unsigned phase;
  uart_byte_t  shift;
  logic        exec_prev;
  logic        done_prev;

  task automatic event_error(string what);
    $display("Error: %s", what);
    event_errs_o = event_errs_o + 1;
  endtask

  task automatic check_reply(uart_byte_t got);
    if (reply_seen_o >= exp_reply_n_i) begin
      event_error($sformatf("unexpected reply byte %02h on txd_o", got));
    end else if (got !== exp_reply_i[reply_seen_o]) begin
      $display("[FAIL] txd_o reply byte %0d expected %02h, got %02h",
               reply_seen_o, exp_reply_i[reply_seen_o], got);
      value_errs_o = value_errs_o + 1;
    end
    reply_seen_o = reply_seen_o + 1;
  endtask

  // Samples on the falling edge, in the middle of the DUT's clock cycle
  always @(negedge clk) begin
    if (rst_i) begin
      busy         <= 1'b0;
      phase        <= 0;
      exec_prev    <= 1'b0;
      done_prev    <= 1'b0;
      reply_seen_o = 0;
      exec_seen_o  = 0;
      ferr_seen_o  = 0;
      value_errs_o = 0;
      event_errs_o = 0;
    end else begin
      exec_prev <= exec_i;
      done_prev <= done_i;

      ////////////////////////////////////////////////////////////
      // Serial reply, one sample per bit at mid-bit
      ////////////////////////////////////////////////////////////
      if (!busy) begin
        if (!txd_i) begin
          busy  <= 1'b1;
          phase <= 1;
        end
      end else begin
        phase <= phase + 1;
        if (phase % clks_per_bit == half_bit) begin
          if (phase / clks_per_bit == 0) begin
            if (txd_i) begin
              event_error("start bit on txd_o did not last to mid-bit");
              busy <= 1'b0;
            end
          end else if (phase / clks_per_bit == stop_slot) begin
            busy <= 1'b0;
            if (!txd_i) event_error("stop bit on txd_o was low");
            check_reply(shift);
          end else begin
            shift <= {txd_i, shift[7:1]};
          end
        end
      end

      // Exec must follow the start of its ACK reply
      if (exec_i && exec_prev) begin
        event_error("exec_o stayed high for more than one cycle");
      end else if (exec_i) begin
        if (!busy && txd_i) event_error("exec_o pulsed before the ACK reply started");
        if (exec_seen_o >= exp_exec_n_i) begin
          event_error("exec_o pulsed with no exec command pending");
        end else if (exec_addr_i !== exp_exec_i[exec_seen_o]) begin
          $display("[FAIL] exec_addr_o expected %016h, got %016h",
                   exp_exec_i[exec_seen_o], exec_addr_i);
          value_errs_o = value_errs_o + 1;
        end
        exec_seen_o = exec_seen_o + 1;
      end

      if (frame_err_i) begin
        if (ferr_seen_o >= exp_ferr_n_i) event_error("unexpected frame_err_o pulse");
        ferr_seen_o = ferr_seen_o + 1;
      end

      // Final count comparison
      if (done_i && !done_prev) begin
        if (busy) event_error("a reply byte was still arriving at the end of the run");
        if (reply_seen_o != exp_reply_n_i) begin
          event_error($sformatf("got %0d reply bytes, expected %0d",
                                reply_seen_o, exp_reply_n_i));
        end
        if (exec_seen_o != exp_exec_n_i) begin
          event_error($sformatf("exec_o pulsed %0d times, expected %0d",
                                exec_seen_o, exp_exec_n_i));
        end
        if (ferr_seen_o != exp_ferr_n_i) begin
          event_error($sformatf("frame_err_o pulsed %0d times, expected %0d",
                                ferr_seen_o, exp_ferr_n_i));
        end
      end
    end
  end

endmodule

// File: testbench/tb_uart_dbg.sv
// Testbench top for the UART debug server.
// Plays a table of host transactions into rxd_i, one row at a time,
// and leaves all comparing to the reply checker.
`timescale 1ns/1ps

module tb_uart_dbg import uart_phy_pkg::*, uart_dbg_pkg::*; #(
  parameter int unsigned seed = 32'h6fd142d2
) ();

  localparam int unsigned max_rows    = 16;
  localparam int unsigned max_tx      = 192;
  localparam int unsigned max_replies = 64;
  localparam int unsigned max_execs   = 4;

  logic        clk;
  logic        rst_i;
  logic        rxd;
  logic        txd;
  logic        exec_pulse;
  dbg_addr_t   exec_addr;
  logic        frame_err;
  logic        checks_done;
  int unsigned reply_seen;
  int unsigned exec_seen;
  int unsigned ferr_seen;
  int unsigned value_errs;
  int unsigned event_errs;

  // Stimulus table, the bytes of all rows back to back
  uart_byte_t  tx_tab        [max_tx];
  int unsigned row_tx_end    [max_rows];
  logic        row_bad_stop  [max_rows];
  int unsigned row_reply_end [max_rows];
  int unsigned row_exec_end  [max_rows];
  int unsigned row_ferr_end  [max_rows];
  uart_byte_t  exp_reply     [max_replies];
  dbg_addr_t   exp_exec      [max_execs];
  // Host side copy of the target memory
  uart_byte_t  model_mem     [mem_depth];

  int unsigned n_rows = 0;
  int unsigned n_tx = 0;
  int unsigned n_replies = 0;
  int unsigned n_execs = 0;
  int unsigned n_ferrs = 0;
  int unsigned timeout_cycles = 0;
  int unsigned cycle_cnt = 0;

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  uart_dbg_top dut_i (
    .clk         ( clk        ),
    .rst_i       ( rst_i      ),
    .rxd_i       ( rxd        ),
    .txd_o       ( txd        ),
    .exec_o      ( exec_pulse ),
    .exec_addr_o ( exec_addr  ),
    .frame_err_o ( frame_err  )
  );

  tb_uart_dbg_checker #(
    .max_replies ( max_replies ),
    .max_execs   ( max_execs   )
  ) chk_i (
    .clk           ( clk         ),
    .rst_i         ( rst_i       ),
    .txd_i         ( txd         ),
    .exec_i        ( exec_pulse  ),
    .exec_addr_i   ( exec_addr   ),
    .frame_err_i   ( frame_err   ),
    .exp_reply_i   ( exp_reply   ),
    .exp_exec_i    ( exp_exec    ),
    .exp_reply_n_i ( n_replies   ),
    .exp_exec_n_i  ( n_execs     ),
    .exp_ferr_n_i  ( n_ferrs     ),
    .done_i        ( checks_done ),
    .reply_seen_o  ( reply_seen  ),
    .exec_seen_o   ( exec_seen   ),
    .ferr_seen_o   ( ferr_seen   ),
    .value_errs_o  ( value_errs  ),
    .event_errs_o  ( event_errs  )
  );

  ////////////////////////////////////////////////////////////
  // Table construction
  ////////////////////////////////////////////////////////////

  task automatic add_tx(uart_byte_t b);
    tx_tab[n_tx] = b;
    n_tx = n_tx + 1;
  endtask

  task automatic add_reply(uart_byte_t b);
    exp_reply[n_replies] = b;
    n_replies = n_replies + 1;
  endtask

  task automatic close_row(logic bad_stop);
    row_tx_end[n_rows]    = n_tx;
    row_bad_stop[n_rows]  = bad_stop;
    row_reply_end[n_rows] = n_replies;
    row_exec_end[n_rows]  = n_execs;
    row_ferr_end[n_rows]  = n_ferrs;
    n_rows = n_rows + 1;
  endtask

  // Command byte, then address and length fields LSB first
  task automatic add_header(uart_byte_t cmd, dbg_addr_t addr, logic [63:0] len_field,
                            logic with_len);
    int unsigned i;
    add_tx(cmd);
    for (i = 0; i < hdr_bytes; i++) begin
      add_tx(addr[7:0]);
      addr = addr >> 8;
    end
    if (with_len) begin
      for (i = 0; i < hdr_bytes; i++) begin
        add_tx(len_field[7:0]);
        len_field = len_field >> 8;
      end
    end
  endtask

  task automatic host_write(dbg_addr_t addr, logic [63:0] len_field);
    dbg_len_t    len;
    uart_byte_t  b;
    int unsigned i;
    len = len_field[15:0];
    add_header(cmd_write, addr, len_field, 1'b1);
    for (i = 0; i < 32'(len); i++) begin
      b = 8'($urandom);
      add_tx(b);
      model_mem[mem_idx_t'(addr + 64'(i))] = b;
    end
    add_reply(dbg_ack);
    add_reply(dbg_eot);
    close_row(1'b0);
  endtask

  task automatic host_read(dbg_addr_t addr, logic [63:0] len_field);
    dbg_len_t    len;
    int unsigned i;
    len = len_field[15:0];
    add_header(cmd_read, addr, len_field, 1'b1);
    add_reply(dbg_ack);
    for (i = 0; i < 32'(len); i++) begin
      add_reply(model_mem[mem_idx_t'(addr + 64'(i))]);
    end
    add_reply(dbg_eot);
    close_row(1'b0);
  endtask

  task automatic host_exec(dbg_addr_t addr);
    add_header(cmd_exec, addr, '0, 1'b0);
    add_reply(dbg_ack);
    exp_exec[n_execs] = addr;
    n_execs = n_execs + 1;
    close_row(1'b0);
  endtask

  task automatic host_ack();
    add_tx(dbg_ack);
    add_reply(dbg_ack);
    close_row(1'b0);
  endtask

  task automatic build_table();
    host_ack();
    host_write(64'h20, 64'd16);
    host_read(64'h20, 64'd16);
    // Wraps past the top of memory, upper address and length bytes set
    host_write(64'h1234_5678_9abc_defc, 64'hff00_0000_a55a_0008);
    host_read(64'hab00_0000_0000_0000, 64'h0000_0000_0001_0004);
    host_exec(64'h0000_0000_8000_1234);
    // ACK byte with a low stop bit, no reply
    add_tx(dbg_ack);
    n_ferrs = n_ferrs + 1;
    close_row(1'b1);
    host_ack();
    // Unknown byte ignored in idle
    add_tx(8'h55);
    add_tx(dbg_ack);
    add_reply(dbg_ack);
    close_row(1'b0);
    host_read(64'h40, 64'd0);
  endtask

  ////////////////////////////////////////////////////////////
  // Host serializer
  ////////////////////////////////////////////////////////////

  // Start, data LSB first, stop, then one idle bit
  task automatic drive_byte(uart_byte_t b, logic stop_bit);
    logic [9:0]  frame;
    int unsigned i;
    frame = {stop_bit, b, 1'b0};
    for (i = 0; i < 11; i++) begin
      @(posedge clk);
      rxd <= frame[0];
      frame = {1'b1, frame[9:1]};
      repeat (clks_per_bit - 1) @(posedge clk);
    end
  endtask

  task automatic apply_row(int unsigned r);
    int unsigned first;
    int unsigned i;
    first = (r == 0) ? 0 : row_tx_end[r - 1];
    for (i = first; i < row_tx_end[r]; i++) begin
      drive_byte(tx_tab[i], !(row_bad_stop[r] && i == first));
    end
    // Row is over once its replies and pulses are all in
    while (reply_seen < row_reply_end[r] || exec_seen < row_exec_end[r] ||
           ferr_seen < row_ferr_end[r]) begin
      @(posedge clk);
    end
  endtask

  initial begin
    int unsigned r;
    rst_i       = 1'b1;
    rxd         = 1'b1;
    checks_done = 1'b0;
    void'($urandom(seed));
    build_table();
    timeout_cycles = n_tx * 2 * 10 * clks_per_bit + 2000;
    repeat (16) @(posedge clk);
    rst_i <= 1'b0;
    for (r = 0; r < n_rows; r++) begin
      apply_row(r);
    end
    // Quiet line so that stray replies still show up
    repeat (20 * clks_per_bit) @(posedge clk);
    checks_done <= 1'b1;
    repeat (2) @(posedge clk);
    $display("Errors: %0d value mismatches, %0d protocol errors", value_errs, event_errs);
    if (value_errs == 0 && event_errs == 0) begin
      $display("TEST PASS");
    end else begin
      $display("TEST FAIL");
    end
    $finish;
  end

  always @(posedge clk) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= timeout_cycles) begin
      $display("Timeout: DUT did not finish the transactions in %0d cycles", timeout_cycles);
      $display("TEST FAIL");
      $finish;
    end
  end

endmodule

// File: vlog.f
logic/uart_phy_pkg.sv
logic/uart_dbg_pkg.sv
logic/uart_rx.sv
logic/uart_tx.sv
logic/dbg_mem.sv
logic/dbg_cmd_engine.sv
logic/uart_dbg_top.sv
testbench/tb_uart_dbg_checker.sv
testbench/tb_uart_dbg.sv

// File: Makefile
# Verilator build and run of the UART debug server testbench

VERILATOR ?= verilator
TOP       ?= tb_uart_dbg
FILELIST  ?= vlog.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
# Decimal form of the default seed 32'h6fd142d2
SEED      ?= 1875985106

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list the targets and variables"
	@echo "  test   build with Verilator, run and check $(LOG) for the pass line"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "Variables: VERILATOR TOP FILELIST BUILD_DIR LOG SEED"

test:
	$(VERILATOR) --binary --assert --timescale 1ns/1ps --Mdir $(BUILD_DIR) \
		--top-module $(TOP) -Gseed=$(SEED) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "^TEST PASS$$" $(LOG) || (echo "Simulation failed, see $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
